// File: ddr3Ctrl.f
+incdir+verilog
verilog/ddr3Pkg.sv
verilog/ddr3InitSeq.sv
verilog/ddr3AccessSched.sv
verilog/ddr3CmdArbiter.sv
verilog/ddr3Ctrl.sv
test/ddr3CtrlTb.sv

// File: test/ddr3CtrlTb.sv
`timescale 1ns/1ps

`include "ddr3Ctrl_defines.svh"

module ddr3CtrlTb
  import ddr3Pkg::*;
();

  localparam int numReq = 24;
  localparam int waitLimit = 1000;

  logic clock;
  logic reset;
  apbReq_t apbReq;
  apbRsp_t apbRsp;
  ddrCmd_t ddrCmd;
  logic cke;
  logic resetN;

  integer seed;
  integer cycleCount;
  // non-NOP commands seen on the bus and the edge that launched each
  logic [22:0] obsCmd[$];
  integer obsCycle[$];
  // model of accepted requests in arrival order
  accessReq_t expReq[$];
  integer expAccept[$];

  logic stimBad[numReq];
  logic stimWrite[numReq];
  logic stimPwrite[numReq];
  logic [7:0] stimAddr[numReq];
  logic [31:0] stimData[numReq];
  integer stimGap[numReq];
  integer goodCount;

  ddr3Ctrl u_ddr3Ctrl (
    .clock  (clock),
    .reset  (reset),
    .apbReq (apbReq),
    .apbRsp (apbRsp),
    .ddrCmd (ddrCmd),
    .cke    (cke),
    .resetN (resetN)
  );

  initial
  begin
    clock = 1'b0;
    forever
      #10 clock = ~clock;
  end

  // rising-edge count that the falling-edge logic reads
  always @(posedge clock)
    cycleCount <= cycleCount + 1;

  // bus monitor that skips NOPs
  always @(negedge clock)
  begin
    if (!reset && !(!ddrCmd.csN && ddrCmd.rasN && ddrCmd.casN && ddrCmd.weN))
    begin
      obsCmd.push_back(ddrCmd);
      obsCycle.push_back(cycleCount);
    end
  end

  // expected command words with cs, ras, cas, we, bank and address
  function automatic logic [22:0] mrsWord(input logic [2:0] bank, input logic [15:0] value);
    mrsWord = {4'b0000, bank, value};
  endfunction

  // ZQ calibration long has A10 high
  function automatic logic [22:0] zqclWord();
    zqclWord = {4'b0110, 3'b000, 16'h0400};
  endfunction

  function automatic logic [22:0] activateWord(input logic [2:0] bank, input logic [13:0] row);
    activateWord = {4'b0011, bank, 2'b00, row};
  endfunction

  // we is high for READ and low for WRITE
  // A10 asks for auto-precharge
  function automatic logic [22:0] columnWord(input logic write, input logic [2:0] bank,
      input logic [9:0] col);
    columnWord = {3'b010, ~write, bank, 5'b00000, 1'b1, col};
  endfunction

  task automatic checkValue(input string name, input logic [31:0] expected,
      input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("** Error: %s expected %h actual %h", name, expected, actual);
      $display("Done: errors found");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic reportTimeout(input string what);
    $display("Timeout: %s never came", what);
    $display("Done: errors found");
    $fatal(1, "stopped on timeout");
  endtask

  task automatic popCommand(input string what, output logic [22:0] cmd, output integer cycle);
    integer waited;
    waited = 0;
    while (obsCmd.size() == 0)
    begin
      @(negedge clock);
      waited++;
      if (waited > waitLimit)
        reportTimeout(what);
    end
    cmd = obsCmd.pop_front();
    cycle = obsCycle.pop_front();
  endtask

  // one APB write or read that returns the completing edge, pslverr and whether it stalled
  task automatic apbTransfer(input logic write, input logic [7:0] addr, input logic [31:0] data,
      output integer acceptCycle, output logic err, output logic stalled);
    integer waited;
    waited = 0;
    @(posedge clock);
    apbReq.psel <= 1'b1;
    apbReq.penable <= 1'b0;
    apbReq.pwrite <= write;
    apbReq.paddr <= addr;
    apbReq.pwdata <= data;
    @(posedge clock);
    apbReq.penable <= 1'b1;
    // access phase held until pready
    @(negedge clock);
    while (!apbRsp.pready)
    begin
      @(negedge clock);
      waited++;
      if (waited > waitLimit)
        reportTimeout("pready");
    end
    acceptCycle = cycleCount + 1;
    err = apbRsp.pslverr;
    stalled = (waited > 0);
    @(posedge clock);
    apbReq.psel <= 1'b0;
    apbReq.penable <= 1'b0;
  endtask

  task automatic checkInitSequence(input integer freeEdge, output integer zqCycle);
    integer waited;
    integer rstHigh;
    integer ckeHigh;
    integer prev;
    integer cycle;
    integer i;
    logic [22:0] cmd;
    logic [2:0] mrBank[4];
    logic [15:0] mrValue[4];
    // load order MR2, MR3, MR1, MR0
    mrBank[0] = 3'd2;
    mrValue[0] = `MR2_VALUE;
    mrBank[1] = 3'd3;
    mrValue[1] = `MR3_VALUE;
    mrBank[2] = 3'd1;
    mrValue[2] = `MR1_VALUE;
    mrBank[3] = 3'd0;
    mrValue[3] = `MR0_VALUE;
    waited = 0;
    while (!resetN)
    begin
      @(negedge clock);
      waited++;
      if (waited > waitLimit)
        reportTimeout("resetN release");
    end
    rstHigh = cycleCount;
    checkValue("init: resetN low cycles", `T_RESET_LOW, rstHigh - freeEdge);
    waited = 0;
    while (!cke)
    begin
      @(negedge clock);
      waited++;
      if (waited > waitLimit)
        reportTimeout("cke rise");
    end
    ckeHigh = cycleCount;
    checkValue("init: cke low cycles", `T_CKE_LOW, ckeHigh - rstHigh);
    prev = ckeHigh;
    for (i = 0; i < 4; i++)
    begin
      popCommand("MRS command", cmd, cycle);
      checkValue("init: MRS word", mrsWord(mrBank[i], mrValue[i]), cmd);
      // first MRS after tXPR and the rest tMRD apart
      checkValue("init: MRS spacing", (i == 0) ? `T_XPR : `T_MRD, cycle - prev);
      prev = cycle;
    end
    popCommand("ZQCL command", cmd, cycle);
    checkValue("init: ZQCL word", zqclWord(), cmd);
    checkValue("init: MR0 to ZQCL", `T_MOD, cycle - prev);
    zqCycle = cycle;
  endtask

  task automatic checkAccesses(input integer count);
    integer n;
    integer waited;
    integer accept;
    integer actCycle;
    integer colCycle;
    integer prevAct;
    logic [22:0] cmd;
    accessReq_t req;
    prevAct = -1000;
    for (n = 0; n < count; n++)
    begin
      waited = 0;
      while (expReq.size() == 0)
      begin
        @(negedge clock);
        waited++;
        if (waited > waitLimit)
          reportTimeout("accepted request");
      end
      req = expReq.pop_front();
      accept = expAccept.pop_front();
      popCommand("ACTIVATE", cmd, actCycle);
      checkValue("access: ACTIVATE word", activateWord(req.bank, req.row), cmd);
      checkValue("access: accept to ACTIVATE", accept + 2, actCycle);
      checkValue("access: tRC between activates", 1, (actCycle - prevAct) >= `T_RC);
      popCommand("READ/WRITE", cmd, colCycle);
      checkValue("access: READ/WRITE word", columnWord(req.write, req.bank, req.col), cmd);
      checkValue("access: tRCD", `T_RCD, colCycle - actCycle);
      prevAct = actCycle;
    end
  endtask

  initial
  begin
    integer i;
    integer firstFreeEdge;
    integer zqCycle;
    integer firstAccept;
    integer accCycle;
    integer lastAccept;
    logic firstErr;
    logic firstStalled;
    logic accErr;
    logic accStalled;
    logic [31:0] r;
    accessReq_t req;
    seed = 32'h4c6d_4cde;
    cycleCount = 0;
    reset = 1'b1;
    apbReq = '0;
    goodCount = 0;
    // stimulus list with roughly one bad transfer in eight
    for (i = 0; i < numReq; i++)
    begin
      r = $random(seed);
      stimBad[i] = (r[2:0] == 3'd0);
      stimWrite[i] = r[3];
      // half the transfers come back to back
      stimGap[i] = r[17] ? 0 : r[19:18];
      stimData[i] = {5'b00000, 27'($random(seed))};
      if (!stimBad[i])
      begin
        stimPwrite[i] = 1'b1;
        stimAddr[i] = r[3] ? `APB_ADDR_WRITE : `APB_ADDR_READ;
        goodCount++;
      end
      else if (r[6])
      begin
        // read of a request register is an error too
        stimPwrite[i] = 1'b0;
        stimAddr[i] = `APB_ADDR_WRITE;
      end
      else
      begin
        stimPwrite[i] = 1'b1;
        stimAddr[i] = 8'h10 | (r[15:8] & 8'hec);
      end
    end
    repeat (8) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    // first edge that samples reset low
    firstFreeEdge = cycleCount + 1;
    fork
      checkInitSequence(firstFreeEdge, zqCycle);
      begin
        // bad address while init is still running
        repeat (5) @(posedge clock);
        apbTransfer(1'b1, 8'h2c, 32'h0, firstAccept, firstErr, firstStalled);
      end
    join
    // initDone comes tZQINIT after ZQCL and the pending transfer one edge later
    checkValue("early transfer: pready low during init", 1, firstStalled);
    checkValue("early transfer: accept edge", zqCycle + `T_ZQINIT + 1, firstAccept);
    checkValue("early transfer: pslverr", 1, firstErr);
    lastAccept = -1000;
    fork
      begin
        for (i = 0; i < numReq; i++)
        begin
          repeat (stimGap[i]) @(posedge clock);
          apbTransfer(stimPwrite[i], stimAddr[i], stimData[i], accCycle, accErr, accStalled);
          checkValue("random: pslverr", stimBad[i], accErr);
          // pready returns tRC after the previous ACTIVATE, two edges after its accept
          // a stalled transfer completes on the edge that follows
          if (accStalled)
            checkValue("random: pready after tRC", lastAccept + 2 + `T_RC + 1, accCycle);
          if (!stimBad[i])
          begin
            // pwdata holds col then row then bank
            req.write = stimWrite[i];
            req.col = stimData[i][9:0];
            req.row = stimData[i][23:10];
            req.bank = stimData[i][26:24];
            expReq.push_back(req);
            expAccept.push_back(accCycle);
            lastAccept = accCycle;
          end
        end
      end
      checkAccesses(goodCount);
    join
    // nothing else may show up on the bus
    repeat (`T_RC) @(posedge clock);
    checkValue("random: no extra commands", 0, obsCmd.size());
    $display("Done: no errors");
    $finish;
  end

endmodule

// File: verilog/ddr3AccessSched.sv
`timescale 1ns/1ps

`include "ddr3Ctrl_defines.svh"

module ddr3AccessSched
  import ddr3Pkg::*;
(
  input  logic    clock,
  input  logic    reset,
  input  apbReq_t apbReq,
  output apbRsp_t apbRsp,
  input  logic    initDone,
  output ddrCmd_t schedCmd,
  output logic    schedCmdValid
);

  localparam int cntW = 16;
  // cycles still owed to tRC once the column command is out
  localparam int rcRest = (`T_RC > `T_RCD) ? (`T_RC - `T_RCD) : 0;

  typedef enum logic [1:0] {
    sIdle,
    sActivate,
    sRcdWait,
    sRcWait
  } schedState_t;

  schedState_t state;
  logic [cntW-1:0] count;
  accessReq_t req;
  ddrCmd_t actCmd;
  ddrCmd_t colCmd;
  logic ready;
  logic apbAccess;
  logic accept;
  logic addrWrite;
  logic addrRead;
  logic goodReq;

  // APB decode
  assign apbAccess = apbReq.psel & apbReq.penable;
  assign addrWrite = (apbReq.paddr == `APB_ADDR_WRITE);
  assign addrRead = (apbReq.paddr == `APB_ADDR_READ);
  // only writes to the two request registers are legal
  assign goodReq = apbReq.pwrite & (addrWrite | addrRead);

  // back-pressure until init is over and no access is in flight
  assign ready = initDone & (state == sIdle);
  assign accept = apbAccess & ready;

  assign apbRsp.pready = ready;
  // error pulse only in the completing access phase
  assign apbRsp.pslverr = accept & ~goodReq;

  // ACTIVATE opens the request's row
  // READ/WRITE always with auto-precharge so the bank closes itself
  always_comb
  begin
    actCmd = ddrNopCmd;
    actCmd.rasN = 1'b0;
    actCmd.bank = req.bank;
    actCmd.addr.row.rowIdx = req.row;
    colCmd = ddrNopCmd;
    colCmd.casN = 1'b0;
    colCmd.weN = ~req.write;
    colCmd.bank = req.bank;
    colCmd.addr.col.colIdx = req.col;
    colCmd.addr.col.autoPre = 1'b1;
  end

  // request capture and launched command word
  always_ff @(posedge clock)
  begin
    if (accept && goodReq)
    begin
      req.write <= addrWrite;
      // pwdata is col low, then row, then bank
      req.col <= apbReq.pwdata[`DDR_COL_W-1:0];
      req.row <= apbReq.pwdata[`DDR_COL_W +: `DDR_ROW_W];
      req.bank <= apbReq.pwdata[`DDR_COL_W+`DDR_ROW_W +: `DDR_BANK_W];
    end
    if (state == sActivate)
      schedCmd <= actCmd;
    else if ((state == sRcdWait) && (count == '0))
      schedCmd <= colCmd;
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      state <= sIdle;
      count <= '0;
      schedCmdValid <= 1'b0;
    end
    else
    begin
      schedCmdValid <= 1'b0;
      case (state)
        sIdle:
        begin
          // bad transfers complete here and issue nothing
          if (accept && goodReq)
            state <= sActivate;
        end
        // launch ACTIVATE, it reaches the pins two edges after accept
        sActivate:
        begin
          schedCmdValid <= 1'b1;
          count <= cntW'(`T_RCD - 1);
          state <= sRcdWait;
        end
        // column command leaves exactly tRCD after the ACTIVATE
        sRcdWait:
        begin
          if (count == '0)
          begin
            schedCmdValid <= 1'b1;
            count <= cntW'(rcRest);
            state <= sRcWait;
          end
          else
            count <= count - 1'b1;
        end
        // hold off the next ACTIVATE until tRC has passed
        default:
        begin
          if (count == '0)
            state <= sIdle;
          else
            count <= count - 1'b1;
        end
      endcase
    end
  end

endmodule

// File: verilog/ddr3CmdArbiter.sv
`timescale 1ns/1ps

module ddr3CmdArbiter
  import ddr3Pkg::*;
(
  input  logic    clock,
  input  logic    reset,
  input  ddrCmd_t initCmd,
  input  logic    initCmdValid,
  input  ddrCmd_t schedCmd,
  input  logic    schedCmdValid,
  output ddrCmd_t ddrCmd
);

  ddrCmd_t nextCmd;

  // sources never overlap, init is checked first anyway
  always_comb
  begin
    if (initCmdValid)
      nextCmd = initCmd;
    else if (schedCmdValid)
      nextCmd = schedCmd;
    else
      nextCmd = ddrNopCmd;
  end

  // one register stage, all command pins switch on the same edge
  always_ff @(posedge clock)
  begin
    if (reset)
      ddrCmd <= ddrNopCmd;
    else
      ddrCmd <= nextCmd;
  end

endmodule

// File: verilog/ddr3Ctrl.sv
`timescale 1ns/1ps

module ddr3Ctrl
  import ddr3Pkg::*;
(
  input  logic    clock,
  input  logic    reset,
  input  apbReq_t apbReq,
  output apbRsp_t apbRsp,
  output ddrCmd_t ddrCmd,
  output logic    cke,
  output logic    resetN
);

  ddrCmd_t initCmd;
  ddrCmd_t schedCmd;
  logic initCmdValid;
  logic schedCmdValid;
  logic initDone;

  // power-up, MRS loads and ZQ calibration
  ddr3InitSeq u_ddr3InitSeq (
    .clock        (clock),
    .reset        (reset),
    .initCmd      (initCmd),
    .initCmdValid (initCmdValid),
    .cke          (cke),
    .resetN       (resetN),
    .initDone     (initDone)
  );

  // APB requests to ACTIVATE plus READ/WRITE
  ddr3AccessSched u_ddr3AccessSched (
    .clock         (clock),
    .reset         (reset),
    .apbReq        (apbReq),
    .apbRsp        (apbRsp),
    .initDone      (initDone),
    .schedCmd      (schedCmd),
    .schedCmdValid (schedCmdValid)
  );

  ddr3CmdArbiter u_ddr3CmdArbiter (
    .clock         (clock),
    .reset         (reset),
    .initCmd       (initCmd),
    .initCmdValid  (initCmdValid),
    .schedCmd      (schedCmd),
    .schedCmdValid (schedCmdValid),
    .ddrCmd        (ddrCmd)
  );

endmodule

// File: verilog/ddr3Ctrl_defines.svh
`ifndef DDR3CTRL_DEFINES_SVH
`define DDR3CTRL_DEFINES_SVH

// bus widths of the x16 DDR3 part
`define DDR_BANK_W 3
`define DDR_ROW_W 14
`define DDR_COL_W 10
`define DDR_ADDR_W 16

// init timing in clock cycles scaled down for simulation
`define T_RESET_LOW 40
`define T_CKE_LOW 60
`define T_XPR 12
`define T_MRD 4
`define T_MOD 12
`define T_ZQINIT 64

// access timing in clock cycles
`define T_RCD 5
`define T_RC 20

// mode register words
// MR0 selects BL8, the CAS latency and DLL reset
`define MR0_VALUE 16'h1124
`define MR1_VALUE 16'h0016
// MR2 selects CWL 5 and dynamic ODT at RZQ/4
`define MR2_VALUE 16'h0200
`define MR3_VALUE 16'h0000

// APB register offsets
`define APB_ADDR_WRITE 8'h00
`define APB_ADDR_READ 8'h04

`endif

// File: verilog/ddr3InitSeq.sv
`timescale 1ns/1ps

`include "ddr3Ctrl_defines.svh"

module ddr3InitSeq
  import ddr3Pkg::*;
(
  input  logic    clock,
  input  logic    reset,
  output ddrCmd_t initCmd,
  output logic    initCmdValid,
  output logic    cke,
  output logic    resetN,
  output logic    initDone
);

  localparam int cntW = 16;

  typedef enum logic [2:0] {
    sResetLow,
    sCkeLow,
    sXpr,
    sMrs,
    sZqcl,
    sDone
  } initState_t;

  initState_t state;
  // shared down-counter, loaded on entry to each phase
  logic [cntW-1:0] count;
  // 0..3 walks MR2, MR3, MR1, MR0
  logic [1:0] mrIdx;
  // first cycle of an MRS or ZQCL phase
  logic cmdFirst;
  logic [`DDR_BANK_W-1:0] mrBank;
  logic [`DDR_ADDR_W-1:0] mrValue;

  // load order MR2, MR3, MR1, MR0
  always_comb
  begin
    case (mrIdx)
      2'd0:
      begin
        mrBank = 3'd2;
        mrValue = `MR2_VALUE;
      end
      2'd1:
      begin
        mrBank = 3'd3;
        mrValue = `MR3_VALUE;
      end
      2'd2:
      begin
        mrBank = 3'd1;
        mrValue = `MR1_VALUE;
      end
      default:
      begin
        mrBank = 3'd0;
        mrValue = `MR0_VALUE;
      end
    endcase
  end

  // MRS is ras/cas/we all low, ZQCL is we low with A10 high
  always_comb
  begin
    initCmd = ddrNopCmd;
    if (state == sMrs)
    begin
      initCmd.rasN = 1'b0;
      initCmd.casN = 1'b0;
      initCmd.weN = 1'b0;
      initCmd.bank = mrBank;
      initCmd.addr.mrs = mrValue;
    end
    else if (state == sZqcl)
    begin
      initCmd.weN = 1'b0;
      initCmd.addr.col.autoPre = 1'b1;
    end
  end

  assign initCmdValid = cmdFirst;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      state <= sResetLow;
      count <= cntW'(`T_RESET_LOW - 1);
      mrIdx <= 2'd0;
      cmdFirst <= 1'b0;
      resetN <= 1'b0;
      cke <= 1'b0;
      initDone <= 1'b0;
    end
    else
    begin
      // pins follow the state one cycle late, same as the arbiter delay
      resetN <= (state != sResetLow);
      cke <= (state != sResetLow) && (state != sCkeLow);
      initDone <= (state == sDone);
      cmdFirst <= 1'b0;
      case (state)
        sResetLow:
        begin
          if (count == '0)
          begin
            state <= sCkeLow;
            count <= cntW'(`T_CKE_LOW - 1);
          end
          else
            count <= count - 1'b1;
        end
        sCkeLow:
        begin
          if (count == '0)
          begin
            state <= sXpr;
            count <= cntW'(`T_XPR - 1);
          end
          else
            count <= count - 1'b1;
        end
        // NOPs with cke high before the first MRS
        sXpr:
        begin
          if (count == '0)
          begin
            state <= sMrs;
            mrIdx <= 2'd0;
            cmdFirst <= 1'b1;
            count <= cntW'(`T_MRD - 1);
          end
          else
            count <= count - 1'b1;
        end
        sMrs:
        begin
          if (count == '0)
          begin
            cmdFirst <= 1'b1;
            if (mrIdx == 2'd3)
            begin
              state <= sZqcl;
              count <= cntW'(`T_ZQINIT - 1);
            end
            else
            begin
              mrIdx <= mrIdx + 1'b1;
              // MR0 comes next, tMOD follows it instead of tMRD
              if (mrIdx == 2'd2)
                count <= cntW'(`T_MOD - 1);
              else
                count <= cntW'(`T_MRD - 1);
            end
          end
          else
            count <= count - 1'b1;
        end
        sZqcl:
        begin
          if (count == '0)
            state <= sDone;
          else
            count <= count - 1'b1;
        end
        default:
          state <= sDone;
      endcase
    end
  end

endmodule

// File: verilog/ddr3Pkg.sv
`include "ddr3Ctrl_defines.svh"

package ddr3Pkg;

  // address bus seen as a row address
  typedef struct packed {
    logic [`DDR_ADDR_W-`DDR_ROW_W-1:0] unused;
    logic [`DDR_ROW_W-1:0] rowIdx;
  } ddrRowAddr_t;

  // address bus seen as a column address, A10 is auto-precharge
  typedef struct packed {
    logic [`DDR_ADDR_W-`DDR_COL_W-2:0] unused;
    logic autoPre;
    logic [`DDR_COL_W-1:0] colIdx;
  } ddrColAddr_t;

  // one address bus, three decodings
  typedef union packed {
    logic [`DDR_ADDR_W-1:0] mrs;
    ddrRowAddr_t row;
    ddrColAddr_t col;
  } ddrAddr_u;

  // command word, control pins active low
  typedef struct packed {
    logic csN;
    logic rasN;
    logic casN;
    logic weN;
    logic [`DDR_BANK_W-1:0] bank;
    ddrAddr_u addr;
  } ddrCmd_t;

  // pending access, held while the scheduler is busy
  typedef struct packed {
    logic write;
    logic [`DDR_BANK_W-1:0] bank;
    logic [`DDR_ROW_W-1:0] row;
    logic [`DDR_COL_W-1:0] col;
  } accessReq_t;

  typedef struct packed {
    logic psel;
    logic penable;
    logic pwrite;
    logic [7:0] paddr;
    logic [31:0] pwdata;
  } apbReq_t;

  typedef struct packed {
    logic pready;
    logic pslverr;
  } apbRsp_t;

  // chip selected, ras/cas/we high, bank and address zero
  parameter ddrCmd_t ddrNopCmd = {1'b0, 1'b1, 1'b1, 1'b1,
    {`DDR_BANK_W{1'b0}}, {`DDR_ADDR_W{1'b0}}};

endpackage
